/* hdl/ppuPkg.sv */
package ppuPkg;

    // raster timing, counted in clocks and lines
    localparam int ACTIVE_W    = 64;
    localparam int TOTAL_W     = 88;
    localparam int HSYNC_START = 68;
    localparam int HSYNC_END   = 76;

    localparam int ACTIVE_H    = 48;
    localparam int TOTAL_H     = 52;
    localparam int VSYNC_START = 49;
    localparam int VSYNC_END   = 51;

    // sprite table and line slots
    localparam int SPRITE_NUM   = 16;
    localparam int SPRITE_IDX_W = 4;
    localparam int SLOT_NUM     = 8;
    localparam int SLOT_W       = 3;
    localparam int SPRITE_SIZE  = 8;

    // colour
    localparam int RGB_W = 12;
    localparam logic [RGB_W-1:0] BG_RGB = 12'h520;

    // posX sits in the low byte, color in the top 12 bits
    typedef struct packed {
        logic [RGB_W-1:0] color;
        logic [1:0]       reserved;
        logic [1:0]       tile;
        logic [7:0]       posY;
        logic [7:0]       posX;
    } spriteFieldsT;

    // host side sees a raw word, the pipeline sees fields
    typedef union packed {
        logic [31:0]  raw;
        spriteFieldsT fields;
    } spriteWordT;

endpackage

/* hdl/spriteLineIf.sv */
interface spriteLineIf;
    import ppuPkg::*;

    // invalidate every slot
    logic              clear;
    // load entry into slot
    logic              wrEn;
    logic [SLOT_W-1:0] slot;
    spriteWordT        entry;

    modport fetch (
        output clear,
        output wrEn,
        output slot,
        output entry
    );

    modport store (
        input clear,
        input wrEn,
        input slot,
        input entry
    );

endinterface

/* hdl/scanTimer.sv */
module scanTimer (
    input  logic       clk,
    input  logic       rstN,
    output logic [7:0] pixX,
    output logic [7:0] pixY,
    output logic       active,
    output logic       hsyncRaw,
    output logic       vsyncRaw,
    output logic       lineEnd
);
    import ppuPkg::*;

    logic [7:0] hNext;
    logic [7:0] vNext;

    // next raster position
    always_comb begin
        hNext = pixX + 8'd1;
        vNext = pixY;
        if (pixX == 8'(TOTAL_W - 1)) begin
            hNext = '0;
            if (pixY == 8'(TOTAL_H - 1)) begin
                vNext = '0;
            end else begin
                vNext = pixY + 8'd1;
            end
        end
    end

    // flags are computed from the next position so they line up with pixX/pixY
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pixX     <= '0;
            pixY     <= '0;
            active   <= 1'b0;
            hsyncRaw <= 1'b1;
            vsyncRaw <= 1'b1;
            lineEnd  <= 1'b0;
        end else begin
            pixX     <= hNext;
            pixY     <= vNext;
            active   <= (hNext < ACTIVE_W) && (vNext < ACTIVE_H);
            hsyncRaw <= !((hNext >= HSYNC_START) && (hNext < HSYNC_END));
            vsyncRaw <= !((vNext >= VSYNC_START) && (vNext < VSYNC_END));
            // first blank clock of the line
            lineEnd  <= (hNext == ACTIVE_W);
        end
    end

endmodule

/* hdl/spriteRam.sv */
module spriteRam (
    input  logic                          clk,
    input  logic                          wrEn,
    input  logic [ppuPkg::SPRITE_IDX_W-1:0] wrAddr,
    input  logic [ppuPkg::SPRITE_IDX_W-1:0] rdAddr,
    input  ppuPkg::spriteWordT            wrData,
    output ppuPkg::spriteWordT            rdData
);
    import ppuPkg::*;

    // raw sprite words, decoded downstream
    logic [31:0] mem [SPRITE_NUM];

    // host write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData.raw;
        end
    end

    // registered read, one cycle of latency
    always_ff @(posedge clk) begin
        rdData.raw <= mem[rdAddr];
    end

endmodule

/* hdl/lineFetchFsm.sv */
module lineFetchFsm (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            lineEnd,
    input  logic [7:0]                      pixY,
    output logic [ppuPkg::SPRITE_IDX_W-1:0] rdAddr,
    input  ppuPkg::spriteWordT              rdData,
    spriteLineIf.fetch                      lineBus
);
    import ppuPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stClear,
        stScan,
        stDrain
    } fetchStateT;

    fetchStateT             state;
    logic [SPRITE_IDX_W-1:0] addrCnt;
    // extra top bit marks all slots taken
    logic [SLOT_W:0]         slotCnt;
    logic [7:0]              targetY;
    logic [7:0]              rowDiff;
    logic                    testing;
    logic                    match;

    assign rdAddr = addrCnt;

    // rdData holds a valid table word during scan and drain
    assign testing = (state == stScan) || (state == stDrain);
    assign rowDiff = targetY - rdData.fields.posY;
    assign match   = testing && (rowDiff < SPRITE_SIZE);

    assign lineBus.clear = (state == stClear);
    assign lineBus.wrEn  = match && !slotCnt[SLOT_W];
    assign lineBus.slot  = slotCnt[SLOT_W-1:0];
    assign lineBus.entry = rdData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= stIdle;
            addrCnt <= '0;
            slotCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (lineEnd) begin
                        state   <= stClear;
                        addrCnt <= '0;
                    end
                end
                stClear: begin
                    // address 0 already issued
                    state   <= stScan;
                    addrCnt <= addrCnt + 1'b1;
                    slotCnt <= '0;
                end
                stScan: begin
                    if (addrCnt == SPRITE_IDX_W'(SPRITE_NUM - 1)) begin
                        state <= stDrain;
                    end else begin
                        addrCnt <= addrCnt + 1'b1;
                    end
                    if (lineBus.wrEn) begin
                        slotCnt <= slotCnt + 1'b1;
                    end
                end
                stDrain: begin
                    // last table word is tested here
                    state <= stIdle;
                    if (lineBus.wrEn) begin
                        slotCnt <= slotCnt + 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // next line, wrapping at the end of the frame
    always_ff @(posedge clk) begin
        if ((state == stIdle) && lineEnd) begin
            if (pixY == 8'(TOTAL_H - 1)) begin
                targetY <= '0;
            end else begin
                targetY <= pixY + 8'd1;
            end
        end
    end

endmodule

/* hdl/lineSpriteBuf.sv */
module lineSpriteBuf (
    input  logic                        clk,
    input  logic                        rstN,
    spriteLineIf.store                  lineBus,
    output ppuPkg::spriteWordT          slotWord [ppuPkg::SLOT_NUM],
    output logic [ppuPkg::SLOT_NUM-1:0] slotValid
);
    import ppuPkg::*;

    // valid bits
    always_ff @(posedge clk) begin
        if (!rstN) begin
            slotValid <= '0;
        end else if (lineBus.clear) begin
            slotValid <= '0;
        end else if (lineBus.wrEn) begin
            slotValid[lineBus.slot] <= 1'b1;
        end
    end

    // sprite words, only meaningful while valid
    always_ff @(posedge clk) begin
        if (lineBus.wrEn) begin
            slotWord[lineBus.slot] <= lineBus.entry;
        end
    end

endmodule

/* hdl/pixelMixer.sv */
module pixelMixer (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [7:0]                  pixX,
    input  logic [7:0]                  pixY,
    input  logic                        active,
    input  logic                        hsyncRaw,
    input  logic                        vsyncRaw,
    input  ppuPkg::spriteWordT          slotWord [ppuPkg::SLOT_NUM],
    input  logic [ppuPkg::SLOT_NUM-1:0] slotValid,
    output logic                        hsync,
    output logic                        vsync,
    output logic                        de,
    output logic [ppuPkg::RGB_W-1:0]    rgb
);
    import ppuPkg::*;

    logic [7:0]       colDiff [SLOT_NUM];
    logic [7:0]       rowDiff [SLOT_NUM];
    logic [SLOT_NUM-1:0] draw;
    logic [RGB_W-1:0] pixColor;

    // built-in 1-bit patterns: solid, checker, left half, diagonal
    function automatic logic tileBit(
        input logic [1:0] tile,
        input logic [2:0] c,
        input logic [2:0] r
    );
        case (tile)
            2'd0:    return 1'b1;
            2'd1:    return ~(r[0] ^ c[0]);
            2'd2:    return ~c[2];
            default: return (c == r);
        endcase
    endfunction

    // hit test per slot
    always_comb begin
        for (int i = 0; i < SLOT_NUM; i++) begin
            colDiff[i] = pixX - slotWord[i].fields.posX;
            rowDiff[i] = pixY - slotWord[i].fields.posY;
            draw[i]    = slotValid[i]
                         && (colDiff[i] < SPRITE_SIZE)
                         && (rowDiff[i] < SPRITE_SIZE)
                         && tileBit(slotWord[i].fields.tile,
                                    colDiff[i][2:0], rowDiff[i][2:0]);
        end
    end

    // walk down so the lowest slot wins
    always_comb begin
        pixColor = BG_RGB;
        for (int i = SLOT_NUM - 1; i >= 0; i--) begin
            if (draw[i]) begin
                pixColor = slotWord[i].fields.color;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            rgb   <= '0;
        end else begin
            hsync <= hsyncRaw;
            vsync <= vsyncRaw;
            de    <= active;
            // black outside the visible area
            rgb   <= active ? pixColor : '0;
        end
    end

endmodule

/* hdl/spritePpu.sv */
module spritePpu (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            wrEn,
    input  logic [ppuPkg::SPRITE_IDX_W-1:0] wrAddr,
    input  logic [31:0]                     wrData,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            de,
    output logic [ppuPkg::RGB_W-1:0]        rgb
);
    import ppuPkg::*;

    logic [7:0]              pixX;
    logic [7:0]              pixY;
    logic                    active;
    logic                    hsyncRaw;
    logic                    vsyncRaw;
    logic                    lineEnd;

    logic [SPRITE_IDX_W-1:0] rdAddr;
    spriteWordT              rdData;

    spriteWordT              slotWord [SLOT_NUM];
    logic [SLOT_NUM-1:0]     slotValid;

    spriteLineIf lineBus ();

    scanTimer i_scanTimer (
        .clk      (clk),
        .rstN     (rstN),
        .pixX     (pixX),
        .pixY     (pixY),
        .active   (active),
        .hsyncRaw (hsyncRaw),
        .vsyncRaw (vsyncRaw),
        .lineEnd  (lineEnd)
    );

    spriteRam i_spriteRam (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .rdAddr (rdAddr),
        .wrData (wrData),
        .rdData (rdData)
    );

    lineFetchFsm i_lineFetchFsm (
        .clk     (clk),
        .rstN    (rstN),
        .lineEnd (lineEnd),
        .pixY    (pixY),
        .rdAddr  (rdAddr),
        .rdData  (rdData),
        .lineBus (lineBus.fetch)
    );

    lineSpriteBuf i_lineSpriteBuf (
        .clk       (clk),
        .rstN      (rstN),
        .lineBus   (lineBus.store),
        .slotWord  (slotWord),
        .slotValid (slotValid)
    );

    pixelMixer i_pixelMixer (
        .clk       (clk),
        .rstN      (rstN),
        .pixX      (pixX),
        .pixY      (pixY),
        .active    (active),
        .hsyncRaw  (hsyncRaw),
        .vsyncRaw  (vsyncRaw),
        .slotWord  (slotWord),
        .slotValid (slotValid),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .rgb       (rgb)
    );

endmodule

/* verification/spritePpu_sva.sv */
module spritePpuSva (
    input logic                     clk,
    input logic                     rstN,
    input logic                     de,
    input logic                     hsync,
    input logic [ppuPkg::RGB_W-1:0] rgb,
    input logic                     lineEnd,
    input logic                     bufClear
);

    // black outside the visible area
    assert property (@(posedge clk) disable iff (!rstN) !de |-> (rgb == '0))
        else $error("rgb is not zero while de is low");

    // sync pulse sits inside the blank
    assert property (@(posedge clk) disable iff (!rstN) de |-> hsync)
        else $error("hsync is low while de is high");

    // clear is the first fetch cycle after the line end
    assert property (@(posedge clk) disable iff (!rstN) bufClear |-> $past(lineEnd))
        else $error("line buffer cleared without a lineEnd one cycle before");

endmodule

bind spritePpu spritePpuSva i_sva (
    .clk      (clk),
    .rstN     (rstN),
    .de       (de),
    .hsync    (hsync),
    .rgb      (rgb),
    .lineEnd  (lineEnd),
    .bufClear (lineBus.clear)
);

/* verification/spritePpuTb.sv */
module spritePpuTb;
    import ppuPkg::*;

    localparam int FRAME_CYCLES = TOTAL_W * TOTAL_H;

    logic                    clk;
    logic                    rstN;
    logic                    wrEn;
    logic [SPRITE_IDX_W-1:0] wrAddr;
    logic [31:0]             wrData;
    logic                    hsync;
    logic                    vsync;
    logic                    de;
    logic [RGB_W-1:0]        rgb;

    // scene A in words 0-15, scene B in words 16-31
    logic [31:0] patterns [2*SPRITE_NUM];
    int          errCount;
    int          testsOk;
    int          testsBad;

    spritePpu i_dut (
        .clk    (clk),
        .rstN   (rstN),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .hsync  (hsync),
        .vsync  (vsync),
        .de     (de),
        .rgb    (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errCount == errBefore) begin
            $display("%s: ok", name);
            testsOk++;
        end else begin
            $display("%s: %0d errors", name, errCount - errBefore);
            testsBad++;
        end
    endtask

    // line select in index order, first drawn sprite wins
    function automatic logic [RGB_W-1:0] expectedRgb(input int base, input int x, input int y);
        logic [31:0] word;
        logic [7:0]  dx;
        logic [7:0]  dy;
        int          taken;
        int          c;
        int          r;
        bit          lit;
        taken = 0;
        for (int i = 0; i < SPRITE_NUM; i++) begin
            word = patterns[base + i];
            dy = 8'(y) - word[15:8];
            if ((dy < SPRITE_SIZE) && (taken < SLOT_NUM)) begin
                taken++;
                dx = 8'(x) - word[7:0];
                if (dx < SPRITE_SIZE) begin
                    c = int'(dx);
                    r = int'(dy);
                    case (word[17:16])
                        2'd0:    lit = 1'b1;
                        2'd1:    lit = ((r + c) % 2) == 0;
                        2'd2:    lit = c < 4;
                        default: lit = c == r;
                    endcase
                    if (lit) return word[31:20];
                end
            end
        end
        return BG_RGB;
    endfunction

    task automatic checkReset();
        int errBefore;
        errBefore = errCount;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checkEq("hsync", 1, hsync);
            checkEq("vsync", 1, vsync);
            checkEq("de", 0, de);
            checkEq("rgb", 0, rgb);
        end
        rstN = 1'b1;
        @(negedge clk);
        // first clock out of reset is still blank
        checkEq("hsync", 1, hsync);
        checkEq("vsync", 1, vsync);
        checkEq("de", 0, de);
        checkEq("rgb", 0, rgb);
        reportTest("reset", errBefore);
    endtask

    task automatic writeScene(input int base);
        for (int i = 0; i < SPRITE_NUM; i++) begin
            @(negedge clk);
            wrEn   = 1'b1;
            wrAddr = SPRITE_IDX_W'(i);
            wrData = patterns[base + i];
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic waitVsyncFall(output bit seen);
        logic prevVs;
        seen   = 1'b0;
        prevVs = vsync;
        for (int n = 0; (n < FRAME_CYCLES + 16) && !seen; n++) begin
            @(negedge clk);
            seen   = prevVs && !vsync;
            prevVs = vsync;
        end
        if (!seen) begin
            $display("vsync never fell within one frame time");
            errCount++;
        end
    endtask

    // one whole frame, from this vsync fall to the next
    task automatic checkFrame(input int base);
        logic             prevVs;
        logic             prevHs;
        logic             prevDe;
        logic [RGB_W-1:0] hiddenRgb;
        int               lineIdx;
        int               pixIdx;
        int               hsFalls;
        int               vsLow;
        int               hidden;
        bit               done;
        hiddenRgb = patterns[base + SLOT_NUM][31:20];
        prevVs  = vsync;
        prevHs  = hsync;
        prevDe  = de;
        lineIdx = -1;
        pixIdx  = 0;
        hsFalls = 0;
        vsLow   = 1;
        hidden  = 0;
        done    = 1'b0;
        for (int n = 0; (n < FRAME_CYCLES + 16) && !done; n++) begin
            @(negedge clk);
            if (prevVs && !vsync) begin
                done = 1'b1;
            end else begin
                if (prevHs && !hsync) hsFalls++;
                if (!vsync) vsLow++;
                if (!prevDe && de) begin
                    lineIdx++;
                    pixIdx = 0;
                end
                if (prevDe && !de) checkEq("de pixels per line", ACTIVE_W, pixIdx);
                if (de) begin
                    checkEq("rgb", expectedRgb(base, pixIdx, lineIdx), rgb);
                    if (rgb == hiddenRgb) hidden++;
                    pixIdx++;
                end else begin
                    checkEq("rgb", 0, rgb);
                end
            end
            prevVs = vsync;
            prevHs = hsync;
            prevDe = de;
        end
        if (!done) begin
            $display("the next vsync falling edge never came");
            errCount++;
        end else begin
            checkEq("visible lines", ACTIVE_H, lineIdx + 1);
            checkEq("hsync falls", TOTAL_H, hsFalls);
            checkEq("vsync low cycles", 2 * TOTAL_W, vsLow);
            // sprite index 8 has to lose its slot
            checkEq("index 8 pixels", 0, hidden);
        end
    endtask

    task automatic runScene(input string name, input int base);
        int errBefore;
        bit seen;
        errBefore = errCount;
        writeScene(base);
        waitVsyncFall(seen);
        if (seen) checkFrame(base);
        reportTest(name, errBefore);
    endtask

    initial begin
        rstN     = 1'b0;
        wrEn     = 1'b0;
        wrAddr   = '0;
        wrData   = '0;
        errCount = 0;
        testsOk  = 0;
        testsBad = 0;
        $readmemh("verification/spritePatterns.hex", patterns);
        if ($isunknown(patterns[2*SPRITE_NUM-1])) begin
            $display("the sprite pattern file could not be read completely");
            errCount++;
        end
        checkReset();
        runScene("scene A", 0);
        runScene("scene B", SPRITE_NUM);
        $display("summary: %0d ok, %0d with errors, %0d errors", testsOk, testsBad, errCount);
        if (errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verification/spritePatterns.hex */
// one sprite word per line: color[31:20] rsv+tile[19:16] posY[15:8] posX[7:0]
// words 0-15 are scene A, words 16-31 are scene B
F0000404
0F010A14
00F21424
FF031E34
0FF12808
F0F20630
88832210
44400606
0000C8C8
0000C8C8
0000C8C8
0000C8C8
0000C8C8
0000C8C8
0000C8C8
0000C8C8
F0001000
0F001004
00F1100C
FF021014
F0F3101C
0FF01024
8881102C
44421034
FFF0103C
0A002C3C
0AA01EC8
ABC0FA14
0000C8C8
0000C8C8
0000C8C8
0000C8C8

/* vlog.f */
hdl/ppuPkg.sv
hdl/spriteLineIf.sv
hdl/scanTimer.sv
hdl/spriteRam.sv
hdl/lineFetchFsm.sv
hdl/lineSpriteBuf.sv
hdl/pixelMixer.sv
hdl/spritePpu.sv
verification/spritePpu_sva.sv
verification/spritePpuTb.sv

/* Bender.yml */
package:
  name: sprite_ppu

sources:
  - hdl/ppuPkg.sv
  - hdl/spriteLineIf.sv
  - hdl/scanTimer.sv
  - hdl/spriteRam.sv
  - hdl/lineFetchFsm.sv
  - hdl/lineSpriteBuf.sv
  - hdl/pixelMixer.sv
  - hdl/spritePpu.sv
  - target: simulation
    files:
      - verification/spritePpu_sva.sv
      - verification/spritePpuTb.sv
